// ==== project.f ====
hw/bus_pkg.sv
hw/mem_pkg.sv
hw/memory_arbiter.sv
hw/bus_ram.sv
hw/mem_subsystem.sv
tb/memory_arbiter_asserts.sv
tb/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the memory subsystem testbench with Verilator and run it
# exit status is 0 only when the log holds the pass line

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=mem_subsystem_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_subsystem_tb \
  --Mdir "$OBJ" -o "$BIN" \
  -f project.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== tb/mem_subsystem_tb.sv ====
//######################################
// memory subsystem testbench
// directed tests of the scalar/vector
// arbiter and the wait-state memory
//######################################

`timescale 1ns/1ps

module mem_subsystem_tb
  import bus_pkg::*;
  import mem_pkg::*;
;

  // accesses summed over all tests, rounded up
  localparam int NUM_ACCESSES   = 80;
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * (2 * MEM_WAIT_CYCLES + 2) + 200;
  // requesting cycles of one access without contention
  localparam int ACCESS_CYCLES  = MEM_WAIT_CYCLES + 1;
  localparam logic [31:0] LFSR_SEED = 32'he815_ecbd;
  // taps 32 22 2 1
  localparam logic [31:0] LFSR_MASK = 32'h8020_0003;
  localparam int FILL_WORDS = 16;

  logic              CLK;
  logic              nRST;
  logic [ADDR_W-1:0] scalar_addr;
  logic              scalar_ren;
  logic              scalar_wen;
  logic [DATA_W-1:0] scalar_wdata;
  logic [BE_W-1:0]   scalar_byte_en;
  logic [DATA_W-1:0] scalar_rdata;
  logic              scalar_busy;
  logic [ADDR_W-1:0] vector_addr;
  logic              vector_ren;
  logic              vector_wen;
  logic [DATA_W-1:0] vector_wdata;
  logic [BE_W-1:0]   vector_byte_en;
  logic [DATA_W-1:0] vector_rdata;
  logic              vector_busy;

  // expected memory contents, merged per byte lane
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];
  logic [31:0]       lfsr;
  int                errors = 0;
  int                accesses = 0;
  int                cycle_cnt = 0;
  // master of each completion, 1 for vector
  bit                done_order[$];

  mem_subsystem i_dut (.*);

  always #2 CLK = ~CLK;

  // watchdog
  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? LFSR_MASK : 32'h0);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // fill value that depends on every address bit
  function automatic logic [31:0] fill_word(input logic [ADDR_W-1:0] addr);
    return ~addr ^ {addr[24:0], addr[31:25]};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERR @%0t: %s, got %h expected %h", $time, what, got, exp);
  endtask

  task automatic ref_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [BE_W-1:0] be);
    logic [MEM_INDEX_W-1:0] idx;
    // upper address bits wrap
    idx = addr[2 +: MEM_INDEX_W];
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        ref_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic drive_master(input bit vec, input logic ren, input logic wen,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [BE_W-1:0] be);
    if (vec) begin
      vector_addr    = addr;
      vector_ren     = ren;
      vector_wen     = wen;
      vector_wdata   = data;
      vector_byte_en = be;
    end else begin
      scalar_addr    = addr;
      scalar_ren     = ren;
      scalar_wen     = wen;
      scalar_wdata   = data;
      scalar_byte_en = be;
    end
  endtask

  task automatic release_master(input bit vec);
    @(posedge CLK);
    #1;
    drive_master(vec, 1'b0, 1'b0, '0, '0, '0);
  endtask

  // a master without a grant must stay stalled and see no data
  task automatic check_idle_side(input bit vec);
    if (vec) begin
      if (vector_busy !== 1'b1) begin
        report_mismatch("vector busy without grant", 32'(vector_busy), 1);
      end
      if (vector_rdata !== '0) begin
        report_mismatch("vector rdata without grant", vector_rdata, 0);
      end
    end else begin
      if (scalar_busy !== 1'b1) begin
        report_mismatch("scalar busy without grant", 32'(scalar_busy), 1);
      end
      if (scalar_rdata !== '0) begin
        report_mismatch("scalar rdata without grant", scalar_rdata, 0);
      end
    end
  endtask

  // holds the request until busy is low, leaves it up afterwards
  task automatic bus_access(input bit vec, input bit wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be,
                            input bit watch_other, output int cycles);
    logic              busy;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] expected;
    bit                done;
    done = 1'b0;
    cycles = 0;
    @(posedge CLK);
    #1;
    drive_master(vec, !wr, wr, addr, data, be);
    while (!done) begin
      // late in the cycle, outputs have settled
      #2;
      cycles++;
      busy = vec ? vector_busy : scalar_busy;
      rdata = vec ? vector_rdata : scalar_rdata;
      if (watch_other) check_idle_side(!vec);
      if (!busy) begin
        done = 1'b1;
        accesses++;
        done_order.push_back(vec);
        if (wr) begin
          ref_write(addr, data, be);
        end else begin
          expected = ref_mem[addr[2 +: MEM_INDEX_W]];
          if (rdata !== expected) begin
            report_mismatch($sformatf("%s read at %h", vec ? "vector" : "scalar", addr),
                            rdata, expected);
          end
        end
      end else begin
        @(posedge CLK);
        #1;
      end
    end
  endtask

  task automatic test_scalar_write_read();
    int cycles;
    bus_access(1'b0, 1'b1, 32'h0000_0080, 32'hdead_beef, 4'hf, 1'b0, cycles);
    release_master(1'b0);
    if (cycles != ACCESS_CYCLES) begin
      report_mismatch("scalar write latency", 32'(cycles), 32'(ACCESS_CYCLES));
    end
    bus_access(1'b0, 1'b0, 32'h0000_0080, '0, '0, 1'b0, cycles);
    release_master(1'b0);
    if (cycles != ACCESS_CYCLES) begin
      report_mismatch("scalar read latency", 32'(cycles), 32'(ACCESS_CYCLES));
    end
  endtask

  task automatic test_byte_enables();
    int cycles;
    bus_access(1'b1, 1'b1, 32'h0000_0090, 32'h1122_3344, 4'hf, 1'b0, cycles);
    release_master(1'b1);
    // lanes 0 and 2 only
    bus_access(1'b1, 1'b1, 32'h0000_0090, 32'haabb_ccdd, 4'b0101, 1'b0, cycles);
    release_master(1'b1);
    bus_access(1'b1, 1'b0, 32'h0000_0090, '0, '0, 1'b0, cycles);
    release_master(1'b1);
  endtask

  task automatic test_simultaneous();
    int vcyc;
    int scyc;
    bus_access(1'b1, 1'b1, 32'h0000_00a0, 32'h0bad_f00d, 4'hf, 1'b0, vcyc);
    release_master(1'b1);
    bus_access(1'b0, 1'b1, 32'h0000_00a4, 32'hcafe_0042, 4'hf, 1'b0, scyc);
    release_master(1'b0);
    fork
      begin
        bus_access(1'b1, 1'b0, 32'h0000_00a0, '0, '0, 1'b0, vcyc);
        release_master(1'b1);
      end
      begin
        bus_access(1'b0, 1'b0, 32'h0000_00a4, '0, '0, 1'b0, scyc);
        release_master(1'b0);
      end
    join
    // vector wins, scalar waits one full access
    if (vcyc != ACCESS_CYCLES) begin
      report_mismatch("vector latency on tie", 32'(vcyc), 32'(ACCESS_CYCLES));
    end
    if (scyc != 2 * ACCESS_CYCLES) begin
      report_mismatch("scalar latency on tie", 32'(scyc), 32'(2 * ACCESS_CYCLES));
    end
  endtask

  // write a, read a, write b, read b without gaps
  task automatic run_stream(input bit vec, input logic [ADDR_W-1:0] base);
    int               cycles;
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = base + ADDR_W'((i / 2) * 4);
      bus_access(vec, (i % 2) == 0, addr, fill_word(addr ^ 32'h0f0f_0000), 4'hf, 1'b0, cycles);
    end
    release_master(vec);
  endtask

  task automatic test_contention();
    done_order.delete();
    fork
      run_stream(1'b1, 32'h0000_0100);
      run_stream(1'b0, 32'h0000_0140);
    join
    for (int k = 0; k < done_order.size(); k++) begin
      // vector completes first, then the masters take turns
      if (done_order[k] != ((k % 2) == 0)) begin
        report_mismatch($sformatf("completion %0d master", k), 32'(done_order[k]),
                        32'((k % 2) == 0));
      end
    end
  endtask

  task automatic test_isolation();
    int cycles;
    bus_access(1'b1, 1'b0, 32'h0000_0080, '0, '0, 1'b1, cycles);
    release_master(1'b1);
    bus_access(1'b0, 1'b0, 32'h0000_0090, '0, '0, 1'b1, cycles);
    release_master(1'b0);
  endtask

  task automatic test_random();
    int                cycles;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       hi;
    logic [31:0]       idx;
    bit                vec;
    bit                wr;
    // give every word of the random window a known value
    for (int i = 0; i < FILL_WORDS; i++) begin
      addr = 32'h1000_0000 | ADDR_W'(i * 4);
      bus_access(i[0], 1'b1, addr, fill_word(addr), 4'hf, 1'b0, cycles);
      release_master(i[0]);
    end
    for (int n = 0; n < 40; n++) begin
      vec = 1'(rand_bits(1));
      wr = 1'(rand_bits(1));
      hi = rand_bits(22);
      idx = rand_bits(4);
      // high bits are random and must wrap onto the window
      addr = {hi[21:0], 4'b0000, idx[3:0], 2'b00};
      bus_access(vec, wr, addr, rand_bits(32), 4'(rand_bits(4)), 1'b0, cycles);
      release_master(vec);
      if (cycles != ACCESS_CYCLES) begin
        report_mismatch("random access latency", 32'(cycles), 32'(ACCESS_CYCLES));
      end
    end
  endtask

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    lfsr = LFSR_SEED;
    drive_master(1'b0, 1'b0, 1'b0, '0, '0, '0);
    drive_master(1'b1, 1'b0, 1'b0, '0, '0, '0);
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    test_scalar_write_read();
    test_byte_enables();
    test_simultaneous();
    test_contention();
    test_isolation();
    test_random();
    $display("accesses %0d, errors %0d", accesses, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb/memory_arbiter_asserts.sv ====
//######################################
// memory arbiter assertions
// grant exclusivity checks bound into
// the arbiter
//######################################

`timescale 1ns/1ps

module memory_arbiter_asserts
  import bus_pkg::*;
(
  input logic                   CLK,
  input logic                   nRST,
  input logic [ARB_STATE_W-1:0] state,
  input logic                   scalar_ren,
  input logic                   scalar_wen,
  input logic                   vector_ren,
  input logic                   vector_wen,
  input logic                   scalar_busy,
  input logic                   vector_busy,
  input logic                   mem_ren,
  input logic                   mem_wen
);

  logic any_req;

  assign any_req = scalar_ren | scalar_wen | vector_ren | vector_wen;

  // only the granted master may see busy low
  busy_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    any_req |-> (scalar_busy || vector_busy))
    else $error("both masters see busy low");

  // read and write never reach the memory together
  ren_wen_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_ren && mem_wen))
    else $error("mem_ren and mem_wen high together");

  // a held grant belongs to a requesting master,
  // which still holds its request in the completion cycle
  vec_grant_valid: assert property (@(posedge CLK) disable iff (!nRST)
    (state == ARB_VEC) |-> (vector_ren || vector_wen))
    else $error("vector grant held without request");

  int_grant_valid: assert property (@(posedge CLK) disable iff (!nRST)
    (state == ARB_INT) |-> (scalar_ren || scalar_wen))
    else $error("scalar grant held without request");

endmodule

bind memory_arbiter memory_arbiter_asserts i_asserts (
  .CLK         (CLK),
  .nRST        (nRST),
  .state       (state),
  .scalar_ren  (scalar_ren),
  .scalar_wen  (scalar_wen),
  .vector_ren  (vector_ren),
  .vector_wen  (vector_wen),
  .scalar_busy (scalar_busy),
  .vector_busy (vector_busy),
  .mem_ren     (mem_ren),
  .mem_wen     (mem_wen)
);

// ==== hw/mem_subsystem.sv ====
//######################################
// memory subsystem
// arbiter in front of a single wait-state
// memory shared by both load/store units
//######################################

`timescale 1ns/1ps

module mem_subsystem
  import bus_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  // scalar load/store unit
  input  logic [ADDR_W-1:0] scalar_addr,
  input  logic              scalar_ren,
  input  logic              scalar_wen,
  input  logic [DATA_W-1:0] scalar_wdata,
  input  logic [BE_W-1:0]   scalar_byte_en,
  output logic [DATA_W-1:0] scalar_rdata,
  output logic              scalar_busy,
  // vector load/store unit
  input  logic [ADDR_W-1:0] vector_addr,
  input  logic              vector_ren,
  input  logic              vector_wen,
  input  logic [DATA_W-1:0] vector_wdata,
  input  logic [BE_W-1:0]   vector_byte_en,
  output logic [DATA_W-1:0] vector_rdata,
  output logic              vector_busy
);

  // arbiter to memory bus
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_ren;
  logic              mem_wen;
  logic [DATA_W-1:0] mem_wdata;
  logic [BE_W-1:0]   mem_byte_en;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_busy;

  memory_arbiter i_arbiter (
    .CLK            (CLK),
    .nRST           (nRST),
    .scalar_addr    (scalar_addr),
    .scalar_ren     (scalar_ren),
    .scalar_wen     (scalar_wen),
    .scalar_wdata   (scalar_wdata),
    .scalar_byte_en (scalar_byte_en),
    .scalar_rdata   (scalar_rdata),
    .scalar_busy    (scalar_busy),
    .vector_addr    (vector_addr),
    .vector_ren     (vector_ren),
    .vector_wen     (vector_wen),
    .vector_wdata   (vector_wdata),
    .vector_byte_en (vector_byte_en),
    .vector_rdata   (vector_rdata),
    .vector_busy    (vector_busy),
    .mem_addr       (mem_addr),
    .mem_ren        (mem_ren),
    .mem_wen        (mem_wen),
    .mem_wdata      (mem_wdata),
    .mem_byte_en    (mem_byte_en),
    .mem_rdata      (mem_rdata),
    .mem_busy       (mem_busy)
  );

  // shared memory behind the granted port
  bus_ram i_ram (
    .CLK     (CLK),
    .nRST    (nRST),
    .addr    (mem_addr),
    .ren     (mem_ren),
    .wen     (mem_wen),
    .wdata   (mem_wdata),
    .byte_en (mem_byte_en),
    .rdata   (mem_rdata),
    .busy    (mem_busy)
  );

endmodule

// ==== hw/bus_ram.sv ====
//######################################
// bus memory
// word memory with fixed wait states,
// byte-enabled writes and a busy output
//######################################

`timescale 1ns/1ps

module bus_ram
  import bus_pkg::*;
  import mem_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic [ADDR_W-1:0] addr,
  input  logic              ren,
  input  logic              wen,
  input  logic [DATA_W-1:0] wdata,
  input  logic [BE_W-1:0]   byte_en,
  output logic [DATA_W-1:0] rdata,
  output logic              busy
);

  logic [DATA_W-1:0]      mem [MEM_WORDS];
  logic [MEM_INDEX_W-1:0] index;
  logic [MEM_WAIT_W-1:0]  wait_cnt;
  logic                   active;
  logic                   done;

  // word index, bits above it are ignored so addresses wrap
  assign index = addr[2 +: MEM_INDEX_W];

  assign active = ren | wen;

  // completion once the request has waited long enough
  assign done = active && (wait_cnt == MEM_WAIT_W'(MEM_WAIT_CYCLES));

  // low when idle and in the completion cycle
  assign busy = active && (wait_cnt < MEM_WAIT_W'(MEM_WAIT_CYCLES));

  // counts requesting cycles of the current access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!active || done) begin
      // restart for the next access
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // write commits at the edge that ends the completion cycle
  always_ff @(posedge CLK) begin
    if (wen && done) begin
      for (int b = 0; b < BE_W; b++) begin
        // only enabled lanes change
        if (byte_en[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // read data is combinational and zero without a read
  assign rdata = ren ? mem[index] : '0;

endmodule

// ==== hw/memory_arbiter.sv ====
//######################################
// memory arbiter
// shares one downstream word bus between the
// vector and the scalar load/store units
//######################################

`timescale 1ns/1ps

module memory_arbiter
  import bus_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  // scalar load/store unit
  input  logic [ADDR_W-1:0] scalar_addr,
  input  logic              scalar_ren,
  input  logic              scalar_wen,
  input  logic [DATA_W-1:0] scalar_wdata,
  input  logic [BE_W-1:0]   scalar_byte_en,
  output logic [DATA_W-1:0] scalar_rdata,
  output logic              scalar_busy,
  // vector load/store unit
  input  logic [ADDR_W-1:0] vector_addr,
  input  logic              vector_ren,
  input  logic              vector_wen,
  input  logic [DATA_W-1:0] vector_wdata,
  input  logic [BE_W-1:0]   vector_byte_en,
  output logic [DATA_W-1:0] vector_rdata,
  output logic              vector_busy,
  // downstream memory port
  output logic [ADDR_W-1:0] mem_addr,
  output logic              mem_ren,
  output logic              mem_wen,
  output logic [DATA_W-1:0] mem_wdata,
  output logic [BE_W-1:0]   mem_byte_en,
  input  logic [DATA_W-1:0] mem_rdata,
  input  logic              mem_busy
);

  logic [ARB_STATE_W-1:0] state;
  logic [ARB_STATE_W-1:0] next_state;
  logic [ARB_STATE_W-1:0] mux_sel;
  logic                   vector_req;
  logic                   scalar_req;

  // a master requests while either enable is up
  assign vector_req = vector_ren | vector_wen;
  assign scalar_req = scalar_ren | scalar_wen;

  // held grant
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      ARB_IDLE: begin
        // vector wins a tie
        if (vector_req) begin
          next_state = ARB_VEC;
        end else if (scalar_req) begin
          next_state = ARB_INT;
        end
      end
      ARB_VEC: begin
        // on completion hand over to a waiting scalar unit
        if (!mem_busy) begin
          next_state = scalar_req ? ARB_INT : ARB_IDLE;
        end
      end
      ARB_INT: begin
        // on completion hand over to a waiting vector unit
        if (!mem_busy) begin
          next_state = vector_req ? ARB_VEC : ARB_IDLE;
        end
      end
      default: begin
        next_state = ARB_IDLE;
      end
    endcase
  end

  // idle uses the fresh grant so an access starts in its request cycle,
  // otherwise the held grant keeps the finishing master connected
  // and breaks the path from mem_busy back into the mux
  assign mux_sel = (state == ARB_IDLE) ? next_state : state;

  always_comb begin
    // ungranted side sees nothing and stays stalled
    mem_addr     = '0;
    mem_ren      = 1'b0;
    mem_wen      = 1'b0;
    mem_wdata    = '0;
    mem_byte_en  = '0;
    scalar_rdata = '0;
    scalar_busy  = 1'b1;
    vector_rdata = '0;
    vector_busy  = 1'b1;
    case (mux_sel)
      ARB_VEC: begin
        mem_addr     = vector_addr;
        mem_ren      = vector_ren;
        mem_wen      = vector_wen;
        mem_wdata    = vector_wdata;
        mem_byte_en  = vector_byte_en;
        vector_rdata = mem_rdata;
        vector_busy  = mem_busy;
      end
      ARB_INT: begin
        mem_addr     = scalar_addr;
        mem_ren      = scalar_ren;
        mem_wen      = scalar_wen;
        mem_wdata    = scalar_wdata;
        mem_byte_en  = scalar_byte_en;
        scalar_rdata = mem_rdata;
        scalar_busy  = mem_busy;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hw/mem_pkg.sv ====
//######################################
// memory package
// size and wait-state timing of the
// word-addressed bus memory
//######################################

package mem_pkg;

  // number of words and the index taken from the byte address
  localparam int MEM_WORDS   = 256;
  localparam int MEM_INDEX_W = $clog2(MEM_WORDS);

  // busy cycles before an access completes
  localparam int MEM_WAIT_CYCLES = 2;

  // wait counter must be able to reach MEM_WAIT_CYCLES
  localparam int MEM_WAIT_W = (MEM_WAIT_CYCLES > 0) ? $clog2(MEM_WAIT_CYCLES + 1) : 1;

endpackage

// ==== hw/bus_pkg.sv ====
//######################################
// bus package
// word bus widths and the state codes of
// the scalar/vector memory arbiter
//######################################

package bus_pkg;

  // byte address and data word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // one enable per byte lane
  localparam int BE_W = DATA_W / 8;

  // arbiter grant state
  localparam int ARB_STATE_W = 2;

  // no master holds the bus
  localparam logic [ARB_STATE_W-1:0] ARB_IDLE = 2'd0;
  // vector load/store unit holds the bus
  localparam logic [ARB_STATE_W-1:0] ARB_VEC  = 2'd1;
  // scalar load/store unit holds the bus
  localparam logic [ARB_STATE_W-1:0] ARB_INT  = 2'd2;

endpackage
